/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_token_engine
FILELIST  ?= token_engine.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep '^TB PASSED$$' > /dev/null

clean:
	rm -rf $(BUILD_DIR)

/* token_engine.f */
verilog/token_engine_pkg.sv
verilog/pass_ctrl.sv
verilog/weight_loader.sv
verilog/lane_fifo_ctrl.sv
verilog/glb_arbiter.sv
verilog/token_engine.sv
verif/tb_glb_fifo_model.sv
verif/tb_token_engine.sv

/* verif/tb_glb_fifo_model.sv */
// behavioral GLB with one-cycle read latency, plus per-lane ifmap and opsum FIFO models
// ifmap FIFOs drain and opsum FIFOs fill at random, rates set by the parameters
`timescale 1ns/1ps

module tb_glb_fifo_model #(
    parameter int NUM_LANE    = 4,
    parameter int MEM_WORDS   = 1024,
    parameter int IFMAP_DEPTH = 2,
    parameter int DRAIN_PCT   = 50, // per-cycle chance an ifmap FIFO loses a word
    parameter int FILL_PCT    = 35  // per-cycle chance an empty opsum FIFO gets a word
) (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  token_engine_pkg::glb_req_t             glb_req_i,
    input  logic                                   fifo_reset_i,
    input  logic [NUM_LANE-1:0]                    ifmap_push_i,
    input  logic [NUM_LANE-1:0]                    opsum_pop_i,
    output token_engine_pkg::data_t                glb_rdata_o,
    output logic [NUM_LANE-1:0]                    ifmap_full_o,
    output logic [NUM_LANE-1:0]                    opsum_empty_o,
    output token_engine_pkg::data_t [NUM_LANE-1:0] opsum_pop_data_o
);
    import token_engine_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(IFMAP_DEPTH + 1);

    data_t                            mem [MEM_WORDS];
    data_t                            rdata_q      = '0;
    logic  [NUM_LANE-1:0][CNT_W-1:0]  ifmap_cnt_q  = '0;
    logic  [NUM_LANE-1:0]             opsum_vld_q  = '0;
    data_t [NUM_LANE-1:0]             opsum_head_q = '0;

    initial begin
        void'($urandom(32'hf66782cb)); // one seed for the whole run
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= $urandom;
        end
    end

    // word addressed, byte offset bits ignored
    always @(posedge clk) begin
        if (glb_req_i.valid) begin
            if (glb_req_i.web == 4'hf) begin
                mem[glb_req_i.addr[2 +: IDX_W]] <= glb_req_i.wdata;
            end else begin
                rdata_q <= mem[glb_req_i.addr[2 +: IDX_W]]; // seen after the edge
            end
        end
    end

    always @(posedge clk) begin
        logic drain;
        if (rst_i || fifo_reset_i) begin
            ifmap_cnt_q <= '0;
            opsum_vld_q <= '0;
        end else begin
            for (int l = 0; l < NUM_LANE; l++) begin
                drain = (ifmap_cnt_q[l] != '0) && (($urandom % 100) < DRAIN_PCT);
                ifmap_cnt_q[l] <= ifmap_cnt_q[l] + CNT_W'(ifmap_push_i[l]) - CNT_W'(drain);
                if (opsum_pop_i[l]) begin
                    opsum_vld_q[l] <= 1'b0;
                end else if (!opsum_vld_q[l] && (($urandom % 100) < FILL_PCT)) begin
                    opsum_vld_q[l]  <= 1'b1;
                    opsum_head_q[l] <= $urandom; // fresh partial sum
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANE; l++) begin
            ifmap_full_o[l] = (ifmap_cnt_q[l] == CNT_W'(IFMAP_DEPTH));
        end
    end

    assign glb_rdata_o      = rdata_q;
    assign opsum_empty_o    = ~opsum_vld_q;
    assign opsum_pop_data_o = opsum_head_q; // head shows without a pop

endmodule

/* verif/tb_token_engine.sv */
// testbench for the token engine, runs three pointwise passes against the GLB and FIFO model
// a posedge monitor checks weight load, FIFO init, pushes, writes and the done pulse
`timescale 1ns/1ps

module tb_token_engine;
    import token_engine_pkg::*;

    localparam int NUM_LANE  = 4;
    localparam int NUM_PE    = NUM_LANE * NUM_LANE;
    localparam int PE_W      = $clog2(NUM_PE);
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int NUM_PASS  = 3;

    // disjoint regions inside the 4 KB model
    localparam addr_t WEIGHT_BASE [NUM_PASS] = '{32'h040, 32'h0c0, 32'h000};
    localparam addr_t IFMAP_BASE  [NUM_PASS] = '{32'h100, 32'h200, 32'h400};
    localparam addr_t OPSUM_BASE  [NUM_PASS] = '{32'h800, 32'h900, 32'ha00};
    localparam int    TILE_LEN    [NUM_PASS] = '{2, 5, 8};

    logic                      clk = 1'b0;
    logic                      rst_i;
    logic                      pass_start_i;
    pass_cfg_t                 cfg_i;
    data_t                     glb_rdata_i;
    logic [NUM_LANE-1:0]       ifmap_full_i;
    logic [NUM_LANE-1:0]       opsum_empty_i;
    data_t [NUM_LANE-1:0]      opsum_pop_data_i;
    glb_req_t                  glb_req_o;
    logic                      weight_load_o;
    logic [PE_W-1:0]           weight_pe_idx_o;
    byte_t                     weight_in_o;
    logic                      fifo_reset_o;
    logic [NUM_LANE-1:0]       ifmap_push_o;
    data_t                     ifmap_push_data_o;
    logic [NUM_LANE-1:0]       opsum_pop_o;
    logic                      pass_done_o;

    // monitor state
    logic in_pass      = 1'b0;
    logic init_seen    = 1'b0;
    logic rst_q        = 1'b0;
    logic fifo_reset_q = 1'b0;
    int   k_wt         = 0;  // weight strobes this pass
    int   done_cnt     = 0;
    int   cycle_cnt    = 0;
    int   push_cnt [NUM_LANE];
    int   wr_cnt   [NUM_LANE];

    token_engine #(
        .NUM_LANE (NUM_LANE)
    ) uut (
        .clk               (clk),
        .rst_i             (rst_i),
        .pass_start_i      (pass_start_i),
        .cfg_i             (cfg_i),
        .glb_rdata_i       (glb_rdata_i),
        .ifmap_full_i      (ifmap_full_i),
        .opsum_empty_i     (opsum_empty_i),
        .opsum_pop_data_i  (opsum_pop_data_i),
        .glb_req_o         (glb_req_o),
        .weight_load_o     (weight_load_o),
        .weight_pe_idx_o   (weight_pe_idx_o),
        .weight_in_o       (weight_in_o),
        .fifo_reset_o      (fifo_reset_o),
        .ifmap_push_o      (ifmap_push_o),
        .ifmap_push_data_o (ifmap_push_data_o),
        .opsum_pop_o       (opsum_pop_o),
        .pass_done_o       (pass_done_o)
    );

    tb_glb_fifo_model #(
        .NUM_LANE  (NUM_LANE),
        .MEM_WORDS (MEM_WORDS)
    ) u_glb (
        .clk              (clk),
        .rst_i            (rst_i),
        .glb_req_i        (glb_req_o),
        .fifo_reset_i     (fifo_reset_o),
        .ifmap_push_i     (ifmap_push_o),
        .opsum_pop_i      (opsum_pop_o),
        .glb_rdata_o      (glb_rdata_i),
        .ifmap_full_o     (ifmap_full_i),
        .opsum_empty_o    (opsum_empty_i),
        .opsum_pop_data_o (opsum_pop_data_i)
    );

    always #20 clk = ~clk;

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic plain_error(input string what);
        $display("t=%0t %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic pass_cfg_t pass_config(input int p);
        pass_cfg_t c;
        c.weight_base = WEIGHT_BASE[p];
        c.ifmap_base  = IFMAP_BASE[p];
        c.opsum_base  = OPSUM_BASE[p];
        c.tile_len    = len_t'(TILE_LEN[p]);
        return c;
    endfunction

    // 20x the weight words plus the per-lane traffic of every pass
    function automatic int cycle_limit();
        int sum;
        sum = 0;
        for (int p = 0; p < NUM_PASS; p++) begin
            sum += 20 * ((NUM_PE / 4) * 5 + 2 * NUM_LANE * TILE_LEN[p]);
        end
        return sum;
    endfunction

    function automatic data_t word_at(input addr_t a);
        return u_glb.mem[a[2 +: MEM_AW]];
    endfunction

    // lane region start, tile_len words per lane
    function automatic addr_t lane_base(input addr_t base, input int lane);
        return base + addr_t'(lane) * addr_t'(cfg_i.tile_len) * addr_t'(4);
    endfunction

    function automatic int lowest_set(input logic [NUM_LANE-1:0] v);
        int idx;
        idx = 0;
        for (int l = NUM_LANE - 1; l >= 0; l--) begin
            if (v[l]) begin
                idx = l;
            end
        end
        return idx;
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit()) begin
            plain_error($sformatf("timeout, passes not finished after %0d cycles", cycle_cnt));
        end
    end

    always @(posedge clk) begin
        data_t exp_w;
        int    lane;
        int    tile;
        tile = int'(cfg_i.tile_len);
        rst_q        <= rst_i;
        fifo_reset_q <= fifo_reset_o;
        if (rst_q) begin // in reset and the cycle after
            assert ({glb_req_o.valid, pass_done_o, fifo_reset_o, weight_load_o,
                     ifmap_push_o, opsum_pop_o} == '0)
                else value_error("outputs after reset", '0, 32'({glb_req_o.valid, pass_done_o,
                                 fifo_reset_o, weight_load_o, ifmap_push_o, opsum_pop_o}));
        end
        if (rst_i) begin
            in_pass  <= 1'b0;
            done_cnt <= 0;
        end else begin
            if (!in_pass) begin
                assert (!glb_req_o.valid && !weight_load_o && !fifo_reset_o && !pass_done_o
                        && ifmap_push_o == '0 && opsum_pop_o == '0)
                    else plain_error("DUT active while no pass is running");
                if (pass_start_i) begin
                    in_pass   <= 1'b1;
                    init_seen <= 1'b0;
                    k_wt      <= 0;
                    for (int l = 0; l < NUM_LANE; l++) begin
                        push_cnt[l] <= 0;
                        wr_cnt[l]   <= 0;
                    end
                end
            end
            if (weight_load_o) begin
                exp_w = word_at(cfg_i.weight_base + addr_t'(4 * (k_wt / 4)));
                assert (!init_seen && k_wt < NUM_PE)
                    else plain_error("weight strobe after the last PE or after FIFO init");
                assert (int'(weight_pe_idx_o) == k_wt)
                    else value_error("weight_pe_idx_o", k_wt, 32'(weight_pe_idx_o));
                assert (weight_in_o == exp_w[8 * (k_wt % 4) +: 8])   // lsb first
                    else value_error("weight_in_o", 32'(exp_w[8 * (k_wt % 4) +: 8]),
                                     32'(weight_in_o));
                k_wt <= k_wt + 1;
            end
            if (fifo_reset_o) begin
                assert (!fifo_reset_q && !init_seen)
                    else plain_error("fifo_reset_o high for more than one cycle");
                assert (k_wt == NUM_PE) else value_error("weight strobe count", NUM_PE, k_wt);
                init_seen <= 1'b1;
            end
            if (glb_req_o.valid) begin
                assert (glb_req_o.addr < addr_t'(4 * MEM_WORDS))
                    else plain_error("GLB access outside the model memory");
                assert (glb_req_o.web == 4'hf || glb_req_o.web == 4'h0)
                    else value_error("glb_req_o.web", 32'h0, 32'(glb_req_o.web));
            end
            if (glb_req_o.valid && glb_req_o.web == 4'hf) begin
                assert ($onehot(opsum_pop_o))
                    else plain_error("GLB write without exactly one opsum pop");
                lane = lowest_set(opsum_pop_o);
                assert (init_seen && wr_cnt[lane] < tile && !opsum_empty_i[lane])
                    else plain_error("opsum write outside the stream or from an empty FIFO");
                assert (glb_req_o.addr == lane_base(cfg_i.opsum_base, lane)
                        + addr_t'(4 * wr_cnt[lane]))
                    else value_error("glb_req_o.addr", lane_base(cfg_i.opsum_base, lane)
                                     + addr_t'(4 * wr_cnt[lane]), glb_req_o.addr);
                assert (glb_req_o.wdata == opsum_pop_data_i[lane])
                    else value_error("glb_req_o.wdata", opsum_pop_data_i[lane], glb_req_o.wdata);
                wr_cnt[lane] <= wr_cnt[lane] + 1;
            end else begin
                assert (opsum_pop_o == '0) else plain_error("opsum pop without a GLB write");
            end
            if (ifmap_push_o != '0) begin
                assert ($onehot(ifmap_push_o)) else plain_error("two lanes push in one cycle");
                lane  = lowest_set(ifmap_push_o);
                exp_w = word_at(lane_base(cfg_i.ifmap_base, lane) + addr_t'(4 * push_cnt[lane]));
                assert (init_seen && push_cnt[lane] < tile)
                    else plain_error("ifmap push outside the stream or past tile_len");
                assert (!ifmap_full_i[lane]) else plain_error("push into a full ifmap FIFO");
                assert (ifmap_push_data_o == exp_w)
                    else value_error("ifmap_push_data_o", exp_w, ifmap_push_data_o);
                push_cnt[lane] <= push_cnt[lane] + 1;
            end
            if (pass_done_o) begin
                for (int l = 0; l < NUM_LANE; l++) begin
                    assert (push_cnt[l] == tile) else value_error("lane push count", tile, push_cnt[l]);
                    assert (wr_cnt[l] == tile) else value_error("lane write count", tile, wr_cnt[l]);
                end
                done_cnt <= done_cnt + 1;
                in_pass  <= 1'b0;
            end
        end
    end

    // extra_at > 0 gives a second start pulse that many cycles into the pass
    task automatic run_pass(input int p, input int extra_at);
        int waited;
        cfg_i        <= pass_config(p);
        pass_start_i <= 1'b1;
        @(posedge clk);
        pass_start_i <= 1'b0;
        waited = 0;
        while (!pass_done_o) begin
            @(posedge clk);
            waited++;
            pass_start_i <= (waited == extra_at);
        end
        pass_start_i <= 1'b0;
        repeat (10) @(posedge clk); // a restarted pass would show up here
        assert (done_cnt == p + 1) else value_error("pass_done_o pulses", p + 1, done_cnt);
    endtask

    initial begin
        rst_i        = 1'b1;
        pass_start_i = 1'b0;
        cfg_i        = '0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk);
        run_pass(0, 0);
        run_pass(1, 5);  // lands in the weight load
        run_pass(2, 40); // lands in the stream phase
        if (done_cnt == NUM_PASS) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("t=%0t pass_done_o pulsed %0d times for %0d passes", $time, done_cnt,
                     NUM_PASS);
            $display("TB FAILED");
            $fatal(1, "wrong number of passes");
        end
    end

endmodule

/* verilog/glb_arbiter.sv */
// single GLB port arbiter, weight first, then opsum writes, then ifmap reads
// lowest lane wins within a class, grant is a same-cycle pulse
`timescale 1ns/1ps

module glb_arbiter #(
    parameter int NUM_LANE = 4
) (
    input  token_engine_pkg::glb_req_t             weight_req_i,
    input  logic [NUM_LANE-1:0]                    ifmap_req_i,
    input  token_engine_pkg::addr_t [NUM_LANE-1:0] ifmap_addr_i,
    input  logic [NUM_LANE-1:0]                    opsum_req_i,
    input  token_engine_pkg::addr_t [NUM_LANE-1:0] opsum_addr_i,
    input  token_engine_pkg::data_t [NUM_LANE-1:0] opsum_wdata_i,
    output token_engine_pkg::glb_req_t             glb_req_o,
    output logic                                   weight_gnt_o,
    output logic [NUM_LANE-1:0]                    ifmap_gnt_o,
    output logic [NUM_LANE-1:0]                    opsum_gnt_o
);

    always_comb begin : pick
        logic taken;
        glb_req_o    = '0;
        weight_gnt_o = 1'b0;
        ifmap_gnt_o  = '0;
        opsum_gnt_o  = '0;
        taken        = 1'b0;

        if (weight_req_i.valid) begin
            glb_req_o    = weight_req_i;
            weight_gnt_o = 1'b1;
            taken        = 1'b1;
        end

        // drain opsum ahead of new ifmap reads
        for (int l = 0; l < NUM_LANE; l++) begin
            if (!taken && opsum_req_i[l]) begin
                glb_req_o.valid = 1'b1;
                glb_req_o.web   = '1; // write
                glb_req_o.addr  = opsum_addr_i[l];
                glb_req_o.wdata = opsum_wdata_i[l];
                opsum_gnt_o[l]  = 1'b1;
                taken           = 1'b1;
            end
        end

        for (int l = 0; l < NUM_LANE; l++) begin
            if (!taken && ifmap_req_i[l]) begin
                glb_req_o.valid = 1'b1;
                glb_req_o.web   = '0; // read, data returns next cycle
                glb_req_o.addr  = ifmap_addr_i[l];
                ifmap_gnt_o[l]  = 1'b1;
                taken           = 1'b1;
            end
        end
    end

endmodule

/* verilog/lane_fifo_ctrl.sv */
// per-lane ifmap read/push and opsum pop/write for one streaming tile
// bases are latched on the init pulse, addresses step one word per transfer
`timescale 1ns/1ps

module lane_fifo_ctrl #(
    parameter int NUM_LANE = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   init_pulse_i,
    input  logic                                   stream_phase_i,
    input  token_engine_pkg::pass_cfg_t            cfg_i,
    input  logic [NUM_LANE-1:0]                    ifmap_full_i,
    input  logic [NUM_LANE-1:0]                    opsum_empty_i,
    input  token_engine_pkg::data_t [NUM_LANE-1:0] opsum_pop_data_i,
    input  logic [NUM_LANE-1:0]                    ifmap_gnt_i,
    input  logic [NUM_LANE-1:0]                    opsum_gnt_i,
    input  token_engine_pkg::data_t                glb_rdata_i,
    output logic                                   fifo_reset_o,
    output logic [NUM_LANE-1:0]                    ifmap_req_o,
    output token_engine_pkg::addr_t [NUM_LANE-1:0] ifmap_addr_o,
    output logic [NUM_LANE-1:0]                    opsum_req_o,
    output token_engine_pkg::addr_t [NUM_LANE-1:0] opsum_addr_o,
    output token_engine_pkg::data_t [NUM_LANE-1:0] opsum_wdata_o,
    output logic [NUM_LANE-1:0]                    ifmap_push_o,
    output token_engine_pkg::data_t                ifmap_push_data_o,
    output logic [NUM_LANE-1:0]                    opsum_pop_o,
    output logic                                   lanes_done_o
);
    import token_engine_pkg::*;

    addr_t [NUM_LANE-1:0] lane_off;     // lane * tile_len words, in bytes
    addr_t [NUM_LANE-1:0] ifmap_addr_q;
    addr_t [NUM_LANE-1:0] opsum_addr_q;
    len_t  [NUM_LANE-1:0] ifmap_cnt_q;  // reads granted
    len_t  [NUM_LANE-1:0] opsum_cnt_q;  // writes granted
    logic  [NUM_LANE-1:0] push_pend_q;  // read data arrives this cycle
    logic  [NUM_LANE-1:0] ifmap_left;
    logic  [NUM_LANE-1:0] opsum_left;
    logic  [NUM_LANE-1:0] lane_done;

    always_comb begin
        for (int l = 0; l < NUM_LANE; l++) begin
            lane_off[l]   = addr_t'(l) * addr_t'(cfg_i.tile_len) * addr_t'(WORD_BYTES);
            ifmap_left[l] = (ifmap_cnt_q[l] != cfg_i.tile_len);
            opsum_left[l] = (opsum_cnt_q[l] != cfg_i.tile_len);
            // no new read while the previous word is still in flight
            ifmap_req_o[l] = stream_phase_i && ifmap_left[l] && !ifmap_full_i[l]
                             && !push_pend_q[l];
            opsum_req_o[l] = stream_phase_i && opsum_left[l] && !opsum_empty_i[l];
            lane_done[l]   = !ifmap_left[l] && !opsum_left[l] && !push_pend_q[l];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || init_pulse_i) begin
            ifmap_cnt_q <= '0;
            opsum_cnt_q <= '0;
            push_pend_q <= '0;
        end else begin
            push_pend_q <= ifmap_gnt_i; // push follows the grant by one edge
            for (int l = 0; l < NUM_LANE; l++) begin
                if (ifmap_gnt_i[l]) begin
                    ifmap_cnt_q[l] <= ifmap_cnt_q[l] + 1'b1;
                end
                if (opsum_gnt_i[l]) begin
                    opsum_cnt_q[l] <= opsum_cnt_q[l] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANE; l++) begin
            if (init_pulse_i) begin
                ifmap_addr_q[l] <= cfg_i.ifmap_base + lane_off[l];
                opsum_addr_q[l] <= cfg_i.opsum_base + lane_off[l];
            end else begin
                if (ifmap_gnt_i[l]) begin
                    ifmap_addr_q[l] <= ifmap_addr_q[l] + addr_t'(WORD_BYTES);
                end
                if (opsum_gnt_i[l]) begin
                    opsum_addr_q[l] <= opsum_addr_q[l] + addr_t'(WORD_BYTES);
                end
            end
        end
    end

    assign fifo_reset_o      = init_pulse_i;
    assign ifmap_addr_o      = ifmap_addr_q;
    assign opsum_addr_o      = opsum_addr_q;
    assign opsum_wdata_o     = opsum_pop_data_i;  // FWFT head goes out with the write
    assign ifmap_push_o      = push_pend_q;
    assign ifmap_push_data_o = glb_rdata_i;       // only one lane can be pending
    assign opsum_pop_o       = opsum_gnt_i;       // pop in the write cycle
    assign lanes_done_o      = stream_phase_i && (&lane_done);

endmodule

/* verilog/pass_ctrl.sv */
// pass sequencer: weight load, one-cycle FIFO init, stream, then a done pulse
// phase levels are decoded straight from the state register
`timescale 1ns/1ps

module pass_ctrl (
    input  logic clk,
    input  logic rst_i,
    input  logic pass_start_i,
    input  logic weight_done_i,
    input  logic lanes_done_i,
    output logic weight_phase_o,
    output logic init_pulse_o,
    output logic stream_phase_o,
    output logic pass_done_o
);
    import token_engine_pkg::*;

    pass_state_e state_q;
    pass_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pass_start_i) begin
                    state_d = LOAD_WEIGHT;
                end
            end
            LOAD_WEIGHT: begin
                if (weight_done_i) begin
                    state_d = INIT_FIFO;
                end
            end
            INIT_FIFO: begin
                state_d = STREAM; // bases latched this cycle
            end
            STREAM: begin
                if (lanes_done_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // start pulses outside IDLE fall through the case above
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign weight_phase_o = (state_q == LOAD_WEIGHT);
    assign init_pulse_o   = (state_q == INIT_FIFO);
    assign stream_phase_o = (state_q == STREAM);
    assign pass_done_o    = (state_q == DONE); // one cycle

endmodule

/* verilog/token_engine.sv */
// token engine top, runs one pointwise pass over a tile
// wires the pass FSM, weight loader, lane FIFO control and GLB arbiter
`timescale 1ns/1ps

module token_engine #(
    parameter int NUM_LANE = 4 // NUM_LANE * NUM_LANE must be a multiple of 4
) (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   pass_start_i,
    input  token_engine_pkg::pass_cfg_t            cfg_i,
    input  token_engine_pkg::data_t                glb_rdata_i,
    input  logic [NUM_LANE-1:0]                    ifmap_full_i,
    input  logic [NUM_LANE-1:0]                    opsum_empty_i,
    input  token_engine_pkg::data_t [NUM_LANE-1:0] opsum_pop_data_i,
    output token_engine_pkg::glb_req_t             glb_req_o,
    output logic                                   weight_load_o,
    output logic [$clog2(NUM_LANE*NUM_LANE)-1:0]   weight_pe_idx_o,
    output token_engine_pkg::byte_t                weight_in_o,
    output logic                                   fifo_reset_o,
    output logic [NUM_LANE-1:0]                    ifmap_push_o,
    output token_engine_pkg::data_t                ifmap_push_data_o,
    output logic [NUM_LANE-1:0]                    opsum_pop_o,
    output logic                                   pass_done_o
);
    import token_engine_pkg::*;

    // phase control
    logic weight_phase;
    logic init_pulse;
    logic stream_phase;
    logic weight_done;
    logic lanes_done;

    // requests and grants around the arbiter
    glb_req_t                  weight_req;
    logic                      weight_gnt;
    logic  [NUM_LANE-1:0]      ifmap_req;
    logic  [NUM_LANE-1:0]      ifmap_gnt;
    addr_t [NUM_LANE-1:0]      ifmap_addr;
    logic  [NUM_LANE-1:0]      opsum_req;
    logic  [NUM_LANE-1:0]      opsum_gnt;
    addr_t [NUM_LANE-1:0]      opsum_addr;
    data_t [NUM_LANE-1:0]      opsum_wdata;

    pass_ctrl u_pass_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .pass_start_i   (pass_start_i),
        .weight_done_i  (weight_done),
        .lanes_done_i   (lanes_done),
        .weight_phase_o (weight_phase),
        .init_pulse_o   (init_pulse),
        .stream_phase_o (stream_phase),
        .pass_done_o    (pass_done_o)
    );

    weight_loader #(
        .NUM_LANE (NUM_LANE)
    ) u_weight_loader (
        .clk             (clk),
        .rst_i           (rst_i),
        .weight_phase_i  (weight_phase),
        .weight_base_i   (cfg_i.weight_base),
        .weight_gnt_i    (weight_gnt),
        .glb_rdata_i     (glb_rdata_i),
        .weight_req_o    (weight_req),
        .weight_load_o   (weight_load_o),
        .weight_pe_idx_o (weight_pe_idx_o),
        .weight_in_o     (weight_in_o),
        .weight_done_o   (weight_done)
    );

    lane_fifo_ctrl #(
        .NUM_LANE (NUM_LANE)
    ) u_lane_fifo_ctrl (
        .clk               (clk),
        .rst_i             (rst_i),
        .init_pulse_i      (init_pulse),
        .stream_phase_i    (stream_phase),
        .cfg_i             (cfg_i),
        .ifmap_full_i      (ifmap_full_i),
        .opsum_empty_i     (opsum_empty_i),
        .opsum_pop_data_i  (opsum_pop_data_i),
        .ifmap_gnt_i       (ifmap_gnt),
        .opsum_gnt_i       (opsum_gnt),
        .glb_rdata_i       (glb_rdata_i),
        .fifo_reset_o      (fifo_reset_o),
        .ifmap_req_o       (ifmap_req),
        .ifmap_addr_o      (ifmap_addr),
        .opsum_req_o       (opsum_req),
        .opsum_addr_o      (opsum_addr),
        .opsum_wdata_o     (opsum_wdata),
        .ifmap_push_o      (ifmap_push_o),
        .ifmap_push_data_o (ifmap_push_data_o),
        .opsum_pop_o       (opsum_pop_o),
        .lanes_done_o      (lanes_done)
    );

    glb_arbiter #(
        .NUM_LANE (NUM_LANE)
    ) u_glb_arbiter (
        .weight_req_i  (weight_req),
        .ifmap_req_i   (ifmap_req),
        .ifmap_addr_i  (ifmap_addr),
        .opsum_req_i   (opsum_req),
        .opsum_addr_i  (opsum_addr),
        .opsum_wdata_i (opsum_wdata),
        .glb_req_o     (glb_req_o),
        .weight_gnt_o  (weight_gnt),
        .ifmap_gnt_o   (ifmap_gnt),
        .opsum_gnt_o   (opsum_gnt)
    );

endmodule

/* verilog/token_engine_pkg.sv */
// shared widths, pass states and bundles for the token engine
// imported by every RTL block and by the testbench
package token_engine_pkg;

    // bytes per GLB word, sets address strides and weight unpacking
    localparam int unsigned WORD_BYTES = 4;

    typedef logic [31:0] addr_t; // GLB byte address
    typedef logic [31:0] data_t; // GLB data word
    typedef logic [7:0]  byte_t; // one weight value
    typedef logic [15:0] len_t;  // words per lane in a tile

    // pass level sequencing
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOAD_WEIGHT = 3'd1,
        INIT_FIFO   = 3'd2, // single cycle
        STREAM      = 3'd3,
        DONE        = 3'd4  // single cycle, pass_done high
    } pass_state_e;

    // tile setup, held stable for the whole pass
    typedef struct packed {
        addr_t weight_base;
        addr_t ifmap_base;
        addr_t opsum_base;
        len_t  tile_len;
    } pass_cfg_t;

    // one access on the GLB port
    // web is all ones for a write, zero for a read
    typedef struct packed {
        logic       valid;
        logic [3:0] web;
        addr_t      addr;
        data_t      wdata;
    } glb_req_t;

endpackage

/* verilog/weight_loader.sv */
// fetches the PE weights from the GLB one word at a time
// each word is unpacked lsb first, one byte per cycle, with a rising PE index
`timescale 1ns/1ps

module weight_loader #(
    parameter int NUM_LANE = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 weight_phase_i,
    input  token_engine_pkg::addr_t              weight_base_i,
    input  logic                                 weight_gnt_i,
    input  token_engine_pkg::data_t              glb_rdata_i,
    output token_engine_pkg::glb_req_t           weight_req_o,
    output logic                                 weight_load_o,
    output logic [$clog2(NUM_LANE*NUM_LANE)-1:0] weight_pe_idx_o,
    output token_engine_pkg::byte_t              weight_in_o,
    output logic                                 weight_done_o
);
    import token_engine_pkg::*;

    localparam int NUM_PE = NUM_LANE * NUM_LANE;
    localparam int PE_W   = $clog2(NUM_PE);
    localparam int BSEL_W = $clog2(WORD_BYTES);

    typedef enum logic [2:0] {
        WL_IDLE,
        WL_REQ,     // request held until granted
        WL_CAPTURE, // read data valid this cycle
        WL_EMIT,
        WL_DONE
    } wl_state_e;

    wl_state_e         state_q;
    logic [PE_W-1:0]   pe_idx_q;
    data_t             word_q;
    logic [BSEL_W-1:0] byte_sel;
    addr_t             word_off;

    assign byte_sel = pe_idx_q[BSEL_W-1:0];
    assign word_off = addr_t'(pe_idx_q / WORD_BYTES) * addr_t'(WORD_BYTES);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= WL_IDLE;
            pe_idx_q <= '0;
        end else begin
            case (state_q)
                WL_IDLE: begin
                    if (weight_phase_i) begin
                        state_q  <= WL_REQ;
                        pe_idx_q <= '0;
                    end
                end
                WL_REQ: begin
                    if (weight_gnt_i) begin
                        state_q <= WL_CAPTURE;
                    end
                end
                WL_CAPTURE: state_q <= WL_EMIT;
                WL_EMIT: begin
                    pe_idx_q <= pe_idx_q + 1'b1;
                    if (pe_idx_q == PE_W'(NUM_PE - 1)) begin
                        state_q <= WL_DONE;
                    end else if (byte_sel == BSEL_W'(WORD_BYTES - 1)) begin
                        state_q <= WL_REQ; // next word only after the last byte
                    end
                end
                default: state_q <= WL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == WL_CAPTURE) begin
            word_q <= glb_rdata_i;
        end
    end

    always_comb begin
        weight_req_o       = '0; // read, web stays zero
        weight_req_o.valid = (state_q == WL_REQ);
        weight_req_o.addr  = weight_base_i + word_off;
    end

    assign weight_load_o   = (state_q == WL_EMIT);
    assign weight_pe_idx_o = pe_idx_q;
    assign weight_in_o     = word_q[8*byte_sel +: 8];
    assign weight_done_o   = (state_q == WL_DONE);

endmodule
